//--- Bender.yml
package:
  name: ps2_calc

sources:
  - include_dirs:
      - design
    files:
      - design/calc_pkg.sv
      - design/ps2_receiver.sv
      - design/scan_code_decoder.sv
      - design/seg7_encoder.sv
      - design/calc_sequencer.sv
      - design/calc_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/calc_tb.sv

//--- build.f
+incdir+design
design/calc_pkg.sv
design/ps2_receiver.sv
design/scan_code_decoder.sv
design/seg7_encoder.sv
design/calc_sequencer.sv
design/calc_top.sv
verif/calc_tb.sv

//--- design/calc_defines.svh
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// ------------------------------------------------------------
// keyboard frame and sampling
// ------------------------------------------------------------
`define PS2_FRAME_BITS 11   // start, eight data bits, parity, stop
`define PS2_SYNC_DEPTH 6    // samples of ps2_clk kept for edge detection

// ------------------------------------------------------------
// arithmetic and display widths
// ------------------------------------------------------------
`define CALC_WIDTH 6        // two's complement, covers -9 to 18 with room for the error code
`define SEG_WIDTH 7         // segments g..a, a zero lights the segment

// fixed glyphs, active low
`define SEG_BLANK  7'b1111111
`define SEG_MINUS  7'b0111111
`define SEG_PLUS   7'b0111001
`define SEG_EQUALS 7'b0111110
`define SEG_ERROR  7'b0000100
`define SEG_ONE    7'b1111001   // lead digit of the results 10 to 18

// scan codes that are not digits
`define SCAN_PLUS   8'h79
`define SCAN_MINUS  8'h7B
`define SCAN_EQUALS 8'h55
`define SCAN_BREAK  8'hF0

`endif

//--- design/calc_pkg.sv
`include "calc_defines.svh"
`default_nettype none

package calc_pkg;

   // ------------------------------------------------------------
   // sequencer states
   // ------------------------------------------------------------
   typedef enum logic [2:0]
   {
      WAIT_OPERAND1 = 3'd0,  // first digit
      WAIT_OPERATOR = 3'd1,  // plus or minus
      WAIT_OPERAND2 = 3'd2,  // second digit
      WAIT_EQUALS   = 3'd3,  // equals key shows the result
      WAIT_BREAK    = 3'd4,  // key accepted, waiting for the F0 prefix
      AFTER_BREAK   = 3'd5   // F0 seen, next frame is the break code
   } calc_state_t;

   // opcode picked by the operator key
   typedef enum logic
   {
      OP_ADD = 1'b0,
      OP_SUB = 1'b1
   } calc_op_t;

   // ------------------------------------------------------------
   // data passed between the blocks
   // ------------------------------------------------------------

   // one received scan code, frame_valid is high for a single cycle
   typedef struct packed
   {
      logic       frame_valid;
      logic [7:0] scan_code;
   } ps2_frame_t;

   // classification of a scan code, exactly one flag is set
   typedef struct packed
   {
      logic       is_digit;
      logic [3:0] digit;       // only meaningful with is_digit
      logic       is_plus;
      logic       is_minus;
      logic       is_equals;
      logic       is_break;
      logic       is_unknown;
   } key_info_t;

   // two glyphs for a signed value
   typedef struct packed
   {
      logic [`SEG_WIDTH-1:0] lead_seg;   // sign or tens
      logic [`SEG_WIDTH-1:0] units_seg;
   } seg_pair_t;

   // the six digits of the display, left to right
   typedef struct packed
   {
      logic [`SEG_WIDTH-1:0] operand1_seg;
      logic [`SEG_WIDTH-1:0] operator_seg;
      logic [`SEG_WIDTH-1:0] operand2_seg;
      logic [`SEG_WIDTH-1:0] equals_seg;
      logic [`SEG_WIDTH-1:0] result_lead_seg;
      logic [`SEG_WIDTH-1:0] result_units_seg;
   } calc_display_t;

endpackage

`default_nettype wire

//--- design/calc_sequencer.sv
`include "calc_defines.svh"
`default_nettype none

module calc_sequencer
(
   input  logic                          sys_clk,
   input  logic                          reset,
   input  calc_pkg::ps2_frame_t          frame,
   input  calc_pkg::key_info_t           key,
   output logic signed [`CALC_WIDTH-1:0] seg_value,
   input  calc_pkg::seg_pair_t           segs,
   output calc_pkg::calc_display_t       display
);

   calc_pkg::calc_state_t         state;
   calc_pkg::calc_state_t         entry_state;   // entry state of the key being released
   calc_pkg::calc_op_t            opcode;
   logic signed [`CALC_WIDTH-1:0] operand1;
   logic signed [`CALC_WIDTH-1:0] operand2;
   logic signed [`CALC_WIDTH-1:0] result;
   logic signed [`CALC_WIDTH-1:0] digit_value;   // decoded digit, or an out of range code
   logic [7:0]                    last_code;     // make code that the break must repeat
   logic                          accept;        // key taken in one of the entry states

   // ------------------------------------------------------------
   // datapath
   // ------------------------------------------------------------

   // a non-digit becomes the most negative value so the encoder shows the error glyph
   assign digit_value = key.is_digit ? {{(`CALC_WIDTH-4){1'b0}}, key.digit}
                                     : {1'b1, {(`CALC_WIDTH-1){1'b0}}};

   assign result = (opcode == calc_pkg::OP_SUB) ? operand1 - operand2
                                                : operand1 + operand2;

   // the encoder shows the result only while equals is expected
   assign seg_value = (state == calc_pkg::WAIT_EQUALS) ? result : digit_value;

   always_comb
   begin
      case (state)
         calc_pkg::WAIT_OPERAND1: accept = key.is_digit;
         calc_pkg::WAIT_OPERATOR: accept = key.is_plus | key.is_minus;
         calc_pkg::WAIT_OPERAND2: accept = key.is_digit;
         calc_pkg::WAIT_EQUALS:   accept = key.is_equals;
         default:                 accept = 1'b0;   // release states take no keys
      endcase
   end

   // operands, opcode and the make code only load on an accepted key
   always_ff @(posedge sys_clk)
   begin
      if (frame.frame_valid && accept)
      begin
         last_code <= frame.scan_code;
         if (state == calc_pkg::WAIT_OPERAND1)
            operand1 <= digit_value;
         if (state == calc_pkg::WAIT_OPERAND2)
            operand2 <= digit_value;
         if (state == calc_pkg::WAIT_OPERATOR)
            opcode <= key.is_minus ? calc_pkg::OP_SUB : calc_pkg::OP_ADD;
      end
   end

   // ------------------------------------------------------------
   // entry FSM and display registers
   // ------------------------------------------------------------
   always_ff @(posedge sys_clk or posedge reset)
   begin
      if (reset)
      begin
         state       <= calc_pkg::WAIT_OPERAND1;
         entry_state <= calc_pkg::WAIT_OPERAND1;
         display     <= '{default: `SEG_BLANK};
      end
      else if (frame.frame_valid)
      begin
         if (accept)
         begin
            entry_state <= state;               // the state to leave once the key is released
            state       <= calc_pkg::WAIT_BREAK;
         end
         case (state)
            calc_pkg::WAIT_OPERAND1:
            begin
               // a new calculation clears the previous one
               display.operator_seg     <= `SEG_BLANK;
               display.operand2_seg     <= `SEG_BLANK;
               display.equals_seg       <= `SEG_BLANK;
               display.result_lead_seg  <= `SEG_BLANK;
               display.result_units_seg <= `SEG_BLANK;
               display.operand1_seg     <= segs.units_seg;   // digit or error glyph
            end
            calc_pkg::WAIT_OPERATOR:
            begin
               if (key.is_plus)
                  display.operator_seg <= `SEG_PLUS;
               else if (key.is_minus)
                  display.operator_seg <= `SEG_MINUS;
               else
                  display.operator_seg <= `SEG_ERROR;
            end
            calc_pkg::WAIT_OPERAND2:
               display.operand2_seg <= segs.units_seg;
            calc_pkg::WAIT_EQUALS:
            begin
               if (key.is_equals)
               begin
                  display.equals_seg       <= `SEG_EQUALS;
                  display.result_lead_seg  <= segs.lead_seg;
                  display.result_units_seg <= segs.units_seg;
               end
               else
                  display.equals_seg <= `SEG_ERROR;
            end
            calc_pkg::WAIT_BREAK:
            begin
               if (key.is_break)
                  state <= calc_pkg::AFTER_BREAK;   // typematic repeats of the make code are ignored
            end
            calc_pkg::AFTER_BREAK:
            begin
               if (frame.scan_code != last_code)
                  state <= calc_pkg::WAIT_BREAK;    // release of some other key, wait again
               else
               begin
                  case (entry_state)
                     calc_pkg::WAIT_OPERAND1: state <= calc_pkg::WAIT_OPERATOR;
                     calc_pkg::WAIT_OPERATOR: state <= calc_pkg::WAIT_OPERAND2;
                     calc_pkg::WAIT_OPERAND2: state <= calc_pkg::WAIT_EQUALS;
                     default:                 state <= calc_pkg::WAIT_OPERAND1;
                  endcase
               end
            end
            default:
               state <= calc_pkg::WAIT_OPERAND1;
         endcase
      end
   end

   assert property (@(posedge sys_clk) disable iff (reset)
                    state inside {calc_pkg::WAIT_OPERAND1, calc_pkg::WAIT_OPERATOR,
                                  calc_pkg::WAIT_OPERAND2, calc_pkg::WAIT_EQUALS,
                                  calc_pkg::WAIT_BREAK, calc_pkg::AFTER_BREAK})
      else $error("sequencer state left the legal encodings");

endmodule

`default_nettype wire

//--- design/calc_top.sv
`include "calc_defines.svh"
`default_nettype none

module calc_top
(
   input  logic                    sys_clk,
   input  logic                    reset,
   input  logic                    ps2_clk,
   input  logic                    ps2_data,
   output calc_pkg::calc_display_t display
);

   calc_pkg::ps2_frame_t          frame;       // one strobe per received scan code
   calc_pkg::key_info_t           key;
   logic signed [`CALC_WIDTH-1:0] seg_value;   // operand digit or result to encode
   calc_pkg::seg_pair_t           segs;

   // ------------------------------------------------------------
   // keyboard side
   // ------------------------------------------------------------
   ps2_receiver u_receiver
   (
      .sys_clk  (sys_clk),
      .reset    (reset),
      .ps2_clk  (ps2_clk),
      .ps2_data (ps2_data),
      .frame    (frame)
   );

   scan_code_decoder u_decoder
   (
      .scan_code (frame.scan_code),
      .key       (key)
   );

   // ------------------------------------------------------------
   // calculation and display
   // ------------------------------------------------------------
   calc_sequencer u_sequencer
   (
      .sys_clk   (sys_clk),
      .reset     (reset),
      .frame     (frame),
      .key       (key),
      .seg_value (seg_value),
      .segs      (segs),
      .display   (display)
   );

   seg7_encoder u_encoder
   (
      .value (seg_value),
      .segs  (segs)
   );

endmodule

`default_nettype wire

//--- design/ps2_receiver.sv
`include "calc_defines.svh"
`default_nettype none

module ps2_receiver
(
   input  logic               sys_clk,
   input  logic               reset,
   input  logic               ps2_clk,   // keyboard clock, only sampled here
   input  logic               ps2_data,
   output calc_pkg::ps2_frame_t frame
);

   logic [`PS2_SYNC_DEPTH-1:0] clk_samples;   // newest sample enters at the top
   logic [`PS2_FRAME_BITS-1:0] frame_bits;    // right shift register, start bit ends at bit 0
   logic                       clk_fall;      // one cycle pulse per falling edge
   logic                       frame_done;    // start bit has reached the bottom
   logic                       frame_valid_q;
   logic [7:0]                 scan_code_q;

   // ------------------------------------------------------------
   // edge detection on the keyboard clock
   // ------------------------------------------------------------

   // three lows on top of three highs, so a short glitch is not an edge
   assign clk_fall = (clk_samples == {{(`PS2_SYNC_DEPTH/2){1'b0}},
                                      {(`PS2_SYNC_DEPTH/2){1'b1}}});

   always_ff @(posedge sys_clk or posedge reset)
   begin
      if (reset)
         clk_samples <= '1;   // idle bus is high
      else
         clk_samples <= {ps2_clk, clk_samples[`PS2_SYNC_DEPTH-1:1]};
   end

   // ------------------------------------------------------------
   // frame assembly
   // ------------------------------------------------------------

   // the frame is filled with ones, the low start bit marks a full frame
   assign frame_done = ~frame_bits[0];

   always_ff @(posedge sys_clk or posedge reset)
   begin
      if (reset)
         frame_bits <= '1;
      else if (frame_done)
         frame_bits <= '1;   // ready for the next frame
      else if (clk_fall)
         frame_bits <= {ps2_data, frame_bits[`PS2_FRAME_BITS-1:1]};   // bits arrive LSB first
   end

   always_ff @(posedge sys_clk or posedge reset)
   begin
      if (reset)
         frame_valid_q <= 1'b0;
      else
         frame_valid_q <= frame_done;   // frame_done lasts one cycle since the reload follows
   end

   // data bits sit between the start bit and the parity bit
   always_ff @(posedge sys_clk)
   begin
      if (frame_done)
         scan_code_q <= frame_bits[8:1];
   end

   assign frame = '{frame_valid: frame_valid_q, scan_code: scan_code_q};

   // the sequencer consumes a frame per strobe, so a long strobe would take one key twice
   assert property (@(posedge sys_clk) disable iff (reset)
                    frame_valid_q |=> !frame_valid_q)
      else $error("frame_valid held high for more than one cycle");

endmodule

`default_nettype wire

//--- design/scan_code_decoder.sv
`include "calc_defines.svh"
`default_nettype none

module scan_code_decoder
(
   input  logic [7:0]          scan_code,
   output calc_pkg::key_info_t key
);

   always_comb
   begin
      key = '0;   // no flag set until a code matches
      case (scan_code)
         // ------------------------------------------------------------
         // main row digits
         // ------------------------------------------------------------
         8'h45: key.digit = 4'd0;
         8'h16: key.digit = 4'd1;
         8'h1E: key.digit = 4'd2;
         8'h26: key.digit = 4'd3;
         8'h25: key.digit = 4'd4;
         8'h2E: key.digit = 4'd5;
         8'h36: key.digit = 4'd6;
         8'h3D: key.digit = 4'd7;
         8'h3E: key.digit = 4'd8;
         8'h46: key.digit = 4'd9;
         // ------------------------------------------------------------
         // keypad digits
         // ------------------------------------------------------------
         8'h70: key.digit = 4'd0;
         8'h69: key.digit = 4'd1;
         8'h72: key.digit = 4'd2;
         8'h7A: key.digit = 4'd3;
         8'h6B: key.digit = 4'd4;
         8'h73: key.digit = 4'd5;
         8'h74: key.digit = 4'd6;
         8'h6C: key.digit = 4'd7;
         8'h75: key.digit = 4'd8;
         8'h7D: key.digit = 4'd9;
         // ------------------------------------------------------------
         // operators and prefix
         // ------------------------------------------------------------
         `SCAN_PLUS:   key.is_plus   = 1'b1;
         `SCAN_MINUS:  key.is_minus  = 1'b1;   // the keypad minus shares this code
         `SCAN_EQUALS: key.is_equals = 1'b1;
         `SCAN_BREAK:  key.is_break  = 1'b1;
         default:      key.is_unknown = 1'b1;
      endcase

      // every digit code above leaves all the other flags clear
      key.is_digit = ~(key.is_plus | key.is_minus | key.is_equals |
                       key.is_break | key.is_unknown);
   end

endmodule

`default_nettype wire

//--- design/seg7_encoder.sv
`include "calc_defines.svh"
`default_nettype none

module seg7_encoder
(
   input  logic signed [`CALC_WIDTH-1:0] value,
   output calc_pkg::seg_pair_t           segs
);

   logic signed [`CALC_WIDTH-1:0] magnitude;   // used for the negative values only
   logic signed [`CALC_WIDTH-1:0] minus_ten;   // units of the two digit results

   // glyph of a single decimal digit, anything above 9 is an error
   function automatic logic [`SEG_WIDTH-1:0] digit_glyph(input logic [3:0] digit);
      case (digit)
         4'd0:    digit_glyph = 7'b1000000;
         4'd1:    digit_glyph = 7'b1111001;
         4'd2:    digit_glyph = 7'b0100100;
         4'd3:    digit_glyph = 7'b0110000;
         4'd4:    digit_glyph = 7'b0011001;
         4'd5:    digit_glyph = 7'b0010010;
         4'd6:    digit_glyph = 7'b0000010;
         4'd7:    digit_glyph = 7'b1111000;
         4'd8:    digit_glyph = 7'b0000000;
         4'd9:    digit_glyph = 7'b0010000;
         default: digit_glyph = `SEG_ERROR;
      endcase
   endfunction

   assign magnitude = -value;
   assign minus_ten = value - `CALC_WIDTH'(10);

   // ------------------------------------------------------------
   // range split, -9..-1, 0..9 and 10..18
   // ------------------------------------------------------------
   always_comb
   begin
      if (value < 0 && value >= -9)
      begin
         segs.lead_seg  = `SEG_MINUS;
         segs.units_seg = digit_glyph(magnitude[3:0]);
      end
      else if (value >= 0 && value <= 9)
      begin
         segs.lead_seg  = `SEG_BLANK;   // single digit needs no lead
         segs.units_seg = digit_glyph(value[3:0]);
      end
      else if (value >= 10 && value <= 18)
      begin
         segs.lead_seg  = `SEG_ONE;
         segs.units_seg = digit_glyph(minus_ten[3:0]);
      end
      else
      begin
         // the sequencer sends an out of range value for a wrong key
         segs.lead_seg  = `SEG_ERROR;
         segs.units_seg = `SEG_ERROR;
      end
   end

endmodule

`default_nettype wire

//--- verif/calc_tb.sv
`include "calc_defines.svh"
`default_nettype none

module calc_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_CYCLES  = 20;   // sys_clk cycles per PS/2 clock half period
   localparam int QUIET_CYCLES = 60;   // idle time after a frame before anything is sampled
   localparam int NUM_FIXED    = 8;
   localparam int NUM_RANDOM   = 10;
   localparam int NUM_ROWS     = NUM_FIXED + NUM_RANDOM;
   localparam int FRAME_CYCLES = `PS2_FRAME_BITS * (2 * HALF_CYCLES + 1) + QUIET_CYCLES;
   // five keys of three frames at most per row, doubled for margin
   localparam int WATCHDOG_NS  = (NUM_ROWS * 15 * FRAME_CYCLES * 2 + 1000) * 40;

   // one calculation, the wrong key is only sent when has_bad is set
   typedef struct packed
   {
      logic [3:0] op1;
      logic       op1_pad;     // keypad code instead of the main row
      logic       is_sub;
      logic [3:0] op2;
      logic       op2_pad;
      logic       has_bad;
      logic [1:0] bad_stage;   // 0 operand1, 1 operator, 2 operand2, 3 equals
      logic [7:0] bad_code;
   } calc_row_t;

   logic                    sys_clk;
   logic                    reset;
   logic                    ps2_clk;
   logic                    ps2_data;
   calc_pkg::calc_display_t display;
   calc_pkg::calc_display_t expected;     // display the rules predict
   calc_row_t               rows [NUM_ROWS];
   logic [7:0]              main_codes [10];
   logic [7:0]              pad_codes [10];
   logic [6:0]              glyph_table [10];   // active low digits 0 to 9
   logic [31:0]             rng_state;

   calc_top UUT
   (
      .sys_clk  (sys_clk),
      .reset    (reset),
      .ps2_clk  (ps2_clk),
      .ps2_data (ps2_data),
      .display  (display)
   );

   always #20 sys_clk = ~sys_clk;

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic calc_row_t make_row(input logic [3:0] op1, input logic op1_pad,
                                          input logic is_sub, input logic [3:0] op2,
                                          input logic op2_pad, input logic has_bad,
                                          input logic [1:0] bad_stage, input logic [7:0] bad_code);
      return '{op1: op1, op1_pad: op1_pad, is_sub: is_sub, op2: op2, op2_pad: op2_pad,
               has_bad: has_bad, bad_stage: bad_stage, bad_code: bad_code};
   endfunction

   function automatic logic [7:0] digit_code(input logic [3:0] digit, input logic pad);
      return pad ? pad_codes[digit] : main_codes[digit];
   endfunction

   // lead and units glyph of a result from -9 to 18
   function automatic logic [13:0] result_pair(input int value);
      if (value < 0)
         return {`SEG_MINUS, glyph_table[-value]};
      else if (value <= 9)
         return {`SEG_BLANK, glyph_table[value]};
      else
         return {`SEG_ONE, glyph_table[value - 10]};
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp_value,
                              input logic [31:0] act_value);
      if (act_value !== exp_value)
      begin
         $display("[FAIL] %s expected %h actual %h", name, exp_value, act_value);
         $display("RESULT: FAIL");
         $fatal(1, "display mismatch");
      end
   endtask

   task automatic check_display();
      check_value("operand1_seg", expected.operand1_seg, display.operand1_seg);
      check_value("operator_seg", expected.operator_seg, display.operator_seg);
      check_value("operand2_seg", expected.operand2_seg, display.operand2_seg);
      check_value("equals_seg", expected.equals_seg, display.equals_seg);
      check_value("result_lead_seg", expected.result_lead_seg, display.result_lead_seg);
      check_value("result_units_seg", expected.result_units_seg, display.result_units_seg);
   endtask

   // ------------------------------------------------------------
   // PS/2 driver
   // ------------------------------------------------------------
   task automatic send_frame(input logic [7:0] code);
      logic [10:0] bits;
      bits = {1'b1, ~^code, code, 1'b0};   // stop, odd parity, data, start
      for (int i = 0; i < `PS2_FRAME_BITS; i++)
      begin
         @(posedge sys_clk);
         ps2_data <= bits[i];              // data moves while the clock is high
         repeat (HALF_CYCLES) @(posedge sys_clk);
         ps2_clk <= 1'b0;
         repeat (HALF_CYCLES) @(posedge sys_clk);
         ps2_clk <= 1'b1;
      end
      repeat (QUIET_CYCLES) @(posedge sys_clk);
   endtask

   // press and release, as a keyboard sends it
   task automatic send_key(input logic [7:0] code);
      send_frame(code);
      send_frame(`SCAN_BREAK);
      send_frame(code);
   endtask

   task automatic apply_row(input calc_row_t row);
      int          value;
      logic [13:0] pair;
      value = row.is_sub ? int'(row.op1) - int'(row.op2) : int'(row.op1) + int'(row.op2);
      pair  = result_pair(value);
      $display("row: %0d %s %0d = %0d", row.op1, row.is_sub ? "-" : "+", row.op2, value);
      expected = '{default: `SEG_BLANK};   // the first operand clears the old calculation
      if (row.has_bad && row.bad_stage == 2'd0)
      begin
         send_key(row.bad_code);
         expected.operand1_seg = `SEG_ERROR;
         check_display();
      end
      send_key(digit_code(row.op1, row.op1_pad));
      expected.operand1_seg = glyph_table[row.op1];
      check_display();
      if (row.has_bad && row.bad_stage == 2'd1)
      begin
         send_key(row.bad_code);
         expected.operator_seg = `SEG_ERROR;
         check_display();
      end
      send_key(row.is_sub ? `SCAN_MINUS : `SCAN_PLUS);
      expected.operator_seg = row.is_sub ? `SEG_MINUS : `SEG_PLUS;
      check_display();
      if (row.has_bad && row.bad_stage == 2'd2)
      begin
         send_key(row.bad_code);
         expected.operand2_seg = `SEG_ERROR;
         check_display();
      end
      send_key(digit_code(row.op2, row.op2_pad));
      expected.operand2_seg = glyph_table[row.op2];
      check_display();
      if (row.has_bad && row.bad_stage == 2'd3)
      begin
         send_key(row.bad_code);
         expected.equals_seg = `SEG_ERROR;
         check_display();
      end
      send_key(`SCAN_EQUALS);
      expected.equals_seg       = `SEG_EQUALS;
      expected.result_lead_seg  = pair[13:7];
      expected.result_units_seg = pair[6:0];
      check_display();
   endtask

   // ------------------------------------------------------------
   // main sequence and watchdog
   // ------------------------------------------------------------
   initial
   begin
      sys_clk   = 1'b0;
      reset     = 1'b1;
      ps2_clk   = 1'b1;   // idle bus
      ps2_data  = 1'b1;
      rng_state = 32'he7d8d52a;
      main_codes  = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};
      pad_codes   = '{8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D};
      glyph_table = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10};

      rows[0] = make_row(4'd9, 1'b0, 1'b0, 4'd9, 1'b0, 1'b0, 2'd0, 8'h00);
      rows[1] = make_row(4'd2, 1'b1, 1'b1, 4'd9, 1'b0, 1'b0, 2'd0, 8'h00);
      rows[2] = make_row(4'd2, 1'b0, 1'b1, 4'd9, 1'b1, 1'b0, 2'd0, 8'h00);
      rows[3] = make_row(4'd5, 1'b0, 1'b0, 4'd3, 1'b1, 1'b1, 2'd0, 8'h1C);   // letter at operand1
      rows[4] = make_row(4'd7, 1'b1, 1'b1, 4'd8, 1'b0, 1'b1, 2'd1, `SCAN_EQUALS);
      rows[5] = make_row(4'd0, 1'b0, 1'b0, 4'd4, 1'b0, 1'b1, 2'd2, `SCAN_MINUS);
      rows[6] = make_row(4'd6, 1'b0, 1'b1, 4'd0, 1'b1, 1'b1, 2'd3, 8'h3E);   // digit at equals
      rows[7] = make_row(4'd1, 1'b1, 1'b0, 4'd2, 1'b0, 1'b1, 2'd0, 8'h12);
      for (int i = NUM_FIXED; i < NUM_ROWS; i++)
      begin
         rng_state = xorshift32(rng_state);
         rows[i]   = make_row(4'(rng_state % 10), rng_state[20], rng_state[27],
                              4'(rng_state[15:8] % 10), rng_state[29], 1'b0, 2'd0, 8'h00);
      end

      repeat (10) @(posedge sys_clk);
      reset <= 1'b0;
      repeat (QUIET_CYCLES) @(posedge sys_clk);
      expected = '{default: `SEG_BLANK};
      check_display();

      for (int i = 0; i < NUM_ROWS; i++)
         apply_row(rows[i]);

      $display("RESULT: PASS");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: the rows did not finish in the expected time");
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire
